// File: verilog/vram_pkg.sv
//////////////////////////////////////////////////
// vram_pkg
// shared types and sizing for the text-mode
// video memory subsystem
//////////////////////////////////////////////////

package vram_pkg;

    localparam int ADDR_BITS = 16;
    localparam int WORD_BITS = 16;
    localparam int NIBBLES   = WORD_BITS / 4;     // one mask bit per nibble

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [NIBBLES-1:0]   mask_t;

    // one VRAM access, 37 bits
    typedef struct packed {
        logic  wr;
        mask_t mask;
        addr_t addr;
        word_t data;
    } vram_req_t;

    localparam int BANK_BITS  = 2;
    localparam int BANKS      = 1 << BANK_BITS;
    localparam int OFS_BITS   = ADDR_BITS - BANK_BITS;
    localparam int BANK_WORDS = 1 << OFS_BITS;    // 16K words per bank

    localparam int HOST_CREDITS = 4;              // also the host queue depth
    localparam int HQ_PTR_BITS  = $clog2(HOST_CREDITS);
    localparam int HQ_CNT_BITS  = $clog2(HOST_CREDITS + 1);

    localparam int DISP_CREDITS = 2;
    localparam int DC_BITS      = $clog2(DISP_CREDITS + 1);

    localparam int LINE_COLS = 8;                 // character words per line
    localparam int COL_BITS  = $clog2(LINE_COLS + 1);

endpackage

// File: verilog/vram_req_if.sv
//////////////////////////////////////////////////
// vram_req_if
// one VRAM access path between a client and
// the arbiter, with read response
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface vram_req_if import vram_pkg::*; ();

    logic      req_valid;   // held until req_grant
    vram_req_t req;
    logic      req_grant;   // taken this cycle
    logic      rsp_valid;   // read data, one cycle after grant
    word_t     rsp_data;

    modport client (
        output req_valid, req,
        input  req_grant, rsp_valid, rsp_data
    );

    modport arbiter (
        input  req_valid, req,
        output req_grant, rsp_valid, rsp_data
    );

endinterface

// File: verilog/host_port.sv
//////////////////////////////////////////////////
// host_port
// host request queue; returns a credit per
// granted entry, read data comes back in order
//////////////////////////////////////////////////
`timescale 1ns/1ps

module host_port import vram_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      host_valid,
    input  vram_req_t host_req,
    output logic      host_credit,
    output logic      rd_valid,
    output word_t     rd_data,
    vram_req_if.client mem
);

    vram_req_t              queue [HOST_CREDITS];
    logic [HQ_PTR_BITS-1:0] wr_ptr;
    logic [HQ_PTR_BITS-1:0] rd_ptr;
    logic [HQ_CNT_BITS-1:0] count;
    logic                   pop;
    logic                   rd_pend;    // read granted last cycle

    assign pop = mem.req_grant;

    // head entry goes straight to the arbiter
    assign mem.req_valid = (count != '0);
    assign mem.req       = queue[rd_ptr];

    assign host_credit = pop;           // slot freed, credit back to host
    assign rd_valid    = mem.rsp_valid;
    assign rd_data     = mem.rsp_data;

    always_ff @(posedge clk) begin
        if (host_valid) begin
            queue[wr_ptr] <= host_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            rd_pend <= 1'b0;
        end else begin
            if (host_valid) begin
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({host_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            rd_pend <= pop && !mem.req.wr;
        end
    end

    // the host only sends while it holds a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        host_valid |-> (count != HQ_CNT_BITS'(HOST_CREDITS)))
        else $error("host_port: push into full queue");

    // responses only follow one of our own read grants
    a_rsp_expected: assert property (@(posedge clk) disable iff (rst)
        mem.rsp_valid |-> rd_pend)
        else $error("host_port: rsp_valid without outstanding read");

endmodule

// File: verilog/text_fetch.sv
//////////////////////////////////////////////////
// text_fetch
// reads one line of character words and streams
// them to the display under its credits
//////////////////////////////////////////////////
`timescale 1ns/1ps

module text_fetch import vram_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  line_start,
    input  addr_t line_base,
    input  logic  disp_credit,
    output logic  char_valid,
    output word_t char_data,
    vram_req_if.client mem
);

    logic                active;      // line fetch in progress
    addr_t               base;
    logic [COL_BITS-1:0] issued;      // reads granted so far
    logic [COL_BITS-1:0] received;    // responses seen so far
    logic [DC_BITS-1:0]  credits;

    // credits only drop on grant, so the request stays up until taken
    assign mem.req_valid = active && (issued != COL_BITS'(LINE_COLS)) && (credits != '0);
    assign mem.req.wr    = 1'b0;
    assign mem.req.mask  = '0;
    assign mem.req.addr  = base + addr_t'(issued);
    assign mem.req.data  = '0;

    assign char_valid = mem.rsp_valid;
    assign char_data  = mem.rsp_data;

    always_ff @(posedge clk) begin
        if (!active && line_start) begin
            base <= line_base;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            issued   <= '0;
            received <= '0;
            credits  <= DC_BITS'(DISP_CREDITS);
        end else begin
            credits <= credits + DC_BITS'(disp_credit) - DC_BITS'(mem.req_grant);
            if (!active) begin
                if (line_start) begin
                    active   <= 1'b1;
                    issued   <= '0;
                    received <= '0;
                end
            end else begin
                if (mem.req_grant) begin
                    issued <= issued + 1'b1;
                end
                if (mem.rsp_valid) begin
                    received <= received + 1'b1;
                    if (received == COL_BITS'(LINE_COLS - 1)) begin
                        active <= 1'b0;    // last char delivered
                    end
                end
            end
        end
    end

    // sink must never hand back more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= DC_BITS'(DISP_CREDITS))
        else $error("text_fetch: display credit count above limit");

endmodule

// File: verilog/vram_arbiter.sv
//////////////////////////////////////////////////
// vram_arbiter
// fixed priority, video before host; drives the
// VRAM strobes and steers read data back
//////////////////////////////////////////////////
`timescale 1ns/1ps

module vram_arbiter import vram_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    vram_req_if.arbiter video,
    vram_req_if.arbiter host,
    output logic  sel,
    output logic  wr_en,
    output mask_t wr_mask,
    output addr_t address_in,
    output word_t data_in,
    input  word_t data_out
);

    vram_req_t pick;
    logic      rd_video;    // owner of the read in flight
    logic      rd_host;

    assign video.req_grant = video.req_valid;
    assign host.req_grant  = host.req_valid && !video.req_valid;

    assign pick = video.req_valid ? video.req : host.req;

    assign sel        = video.req_valid || host.req_valid;
    assign wr_en      = sel && pick.wr;
    assign wr_mask    = pick.mask;
    assign address_in = pick.addr;
    assign data_in    = pick.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_video <= 1'b0;
            rd_host  <= 1'b0;
        end else begin
            rd_video <= video.req_grant && !video.req.wr;
            rd_host  <= host.req_grant && !host.req.wr;
        end
    end

    // vram output is registered, so data lines up with the owner flag
    assign video.rsp_valid = rd_video;
    assign video.rsp_data  = data_out;
    assign host.rsp_valid  = rd_host;
    assign host.rsp_data   = data_out;

    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        !(video.req_grant && host.req_grant))
        else $error("vram_arbiter: two grants in one cycle");

    // a waiting host request must not change under us
    a_host_hold: assert property (@(posedge clk) disable iff (rst)
        host.req_valid && !host.req_grant |=> host.req_valid && $stable(host.req))
        else $error("vram_arbiter: host request dropped or changed before grant");

endmodule

// File: verilog/vram.sv
//////////////////////////////////////////////////
// vram
// four 16K-word banks, nibble-masked write and a
// registered read of the previous contents
//////////////////////////////////////////////////
`timescale 1ns/1ps

module vram import vram_pkg::*; (
    input  logic  clk,
    input  logic  sel,
    input  logic  wr_en,
    input  mask_t wr_mask,
    input  addr_t address_in,
    input  word_t data_in,
    output word_t data_out
);

    logic [BANK_BITS-1:0] bank;
    logic [OFS_BITS-1:0]  offset;
    logic [BANK_BITS-1:0] read_bank;    // bank of the last access
    word_t                bank_q [BANKS];

    assign bank   = address_in[ADDR_BITS-1 -: BANK_BITS];
    assign offset = address_in[OFS_BITS-1:0];

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        word_t mem [BANK_WORDS];
        logic  bank_sel;

        assign bank_sel = sel && (bank == BANK_BITS'(b));

        always_ff @(posedge clk) begin
            if (bank_sel) begin
                if (wr_en) begin
                    for (int n = 0; n < NIBBLES; n++) begin
                        if (wr_mask[n]) begin
                            mem[offset][4*n +: 4] <= data_in[4*n +: 4];
                        end
                    end
                end
                bank_q[b] <= mem[offset];    // old word, read before write
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel) begin
            read_bank <= bank;
        end
    end

    assign data_out = bank_q[read_bank];

endmodule

// File: verilog/vram_subsys.sv
//////////////////////////////////////////////////
// vram_subsys
// host port, text fetcher and arbiter sharing
// one single-port VRAM
//////////////////////////////////////////////////
`timescale 1ns/1ps

module vram_subsys import vram_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  host_valid,
    input  logic  host_wr,
    input  mask_t host_mask,
    input  addr_t host_addr,
    input  word_t host_data,
    output logic  host_credit,
    output logic  rd_valid,
    output word_t rd_data,
    input  logic  line_start,
    input  addr_t line_base,
    input  logic  disp_credit,
    output logic  char_valid,
    output word_t char_data
);

    vram_req_t host_req;
    logic      sel;
    logic      wr_en;
    mask_t     wr_mask;
    addr_t     address_in;
    word_t     data_in;
    word_t     data_out;

    assign host_req = '{wr: host_wr, mask: host_mask, addr: host_addr, data: host_data};

    vram_req_if i_host_if ();
    vram_req_if i_video_if ();

    host_port i_host_port (
        .clk         (clk),
        .rst         (rst),
        .host_valid  (host_valid),
        .host_req    (host_req),
        .host_credit (host_credit),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .mem         (i_host_if.client)
    );

    text_fetch i_text_fetch (
        .clk         (clk),
        .rst         (rst),
        .line_start  (line_start),
        .line_base   (line_base),
        .disp_credit (disp_credit),
        .char_valid  (char_valid),
        .char_data   (char_data),
        .mem         (i_video_if.client)
    );

    vram_arbiter i_vram_arbiter (
        .clk        (clk),
        .rst        (rst),
        .video      (i_video_if.arbiter),
        .host       (i_host_if.arbiter),
        .sel        (sel),
        .wr_en      (wr_en),
        .wr_mask    (wr_mask),
        .address_in (address_in),
        .data_in    (data_in),
        .data_out   (data_out)
    );

    vram i_vram (
        .clk        (clk),
        .sel        (sel),
        .wr_en      (wr_en),
        .wr_mask    (wr_mask),
        .address_in (address_in),
        .data_in    (data_in),
        .data_out   (data_out)
    );

endmodule

// File: testbench/tb_vram_subsys.sv
//////////////////////////////////////////////////
// tb_vram_subsys
// host and line-fetch traffic against a shadow
// memory, checked by concurrent assertions
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_vram_subsys import vram_pkg::*; ();

    logic  clk;
    logic  rst;
    logic  host_valid;
    logic  host_wr;
    mask_t host_mask;
    addr_t host_addr;
    word_t host_data;
    logic  host_credit;
    logic  rd_valid;
    word_t rd_data;
    logic  line_start;
    addr_t line_base;
    logic  disp_credit;
    logic  char_valid;
    word_t char_data;

    word_t shadow [1 << ADDR_BITS];
    word_t rd_exp [1024];           // expected read data in issue order
    addr_t test_addr [16];
    addr_t fetch_base;
    int    seed = 32'h9da6_1aee;
    int    errors = 0;
    int    cycles = 0;
    int    rd_issued = 0;
    int    rd_head;
    int    accepted;
    int    credit_pulses;
    int    credits_held;
    int    char_cnt;                // chars of the current line
    int    chars_total;
    int    disp_returned;
    logic  started = 1'b0;

    vram_subsys i_vram_subsys (.*);

    always #50 clk = ~clk;

    assign credits_held = HOST_CREDITS - accepted + credit_pulses;

    always @(posedge clk) begin
        if (rst) begin
            rd_head       <= 0;
            accepted      <= 0;
            credit_pulses <= 0;
            char_cnt      <= 0;
            chars_total   <= 0;
            disp_returned <= 0;
        end else begin
            if (host_valid) accepted <= accepted + 1;
            if (host_credit) credit_pulses <= credit_pulses + 1;
            if (rd_valid) rd_head <= rd_head + 1;
            if (line_start) begin
                char_cnt   <= 0;
                fetch_base <= line_base;
            end else if (char_valid) begin
                char_cnt <= char_cnt + 1;
            end
            if (char_valid) chars_total <= chars_total + 1;
            if (disp_credit) disp_returned <= disp_returned + 1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (rst)
        !started |-> !host_credit && !rd_valid && !char_valid)
        else begin
            errors++;
            $display("ERROR host_credit %h rd_valid %h char_valid %h expected 0",
                     $sampled(host_credit), $sampled(rd_valid), $sampled(char_valid));
        end

    a_rd_data: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> rd_head < rd_issued && rd_data == rd_exp[rd_head])
        else begin
            errors++;
            $display("ERROR rd_data got %h expected %h", $sampled(rd_data),
                     $sampled(rd_exp[rd_head]));
        end

    a_host_max: assert property (@(posedge clk) disable iff (rst)
        credits_held <= HOST_CREDITS)
        else begin
            errors++;
            $display("ERROR credits_held %h above %h", $sampled(credits_held), HOST_CREDITS);
        end

    a_credit_src: assert property (@(posedge clk) disable iff (rst)
        host_credit |-> credit_pulses < accepted)
        else begin
            errors++;
            $display("host_credit pulse without a queued request");
        end

    a_char_data: assert property (@(posedge clk) disable iff (rst)
        char_valid |-> char_cnt < LINE_COLS && char_data == shadow[fetch_base + addr_t'(char_cnt)])
        else begin
            errors++;
            $display("ERROR char_data got %h expected %h", $sampled(char_data),
                     $sampled(shadow[fetch_base + addr_t'(char_cnt)]));
        end

    a_disp_flow: assert property (@(posedge clk) disable iff (rst)
        char_valid |-> chars_total < disp_returned + DISP_CREDITS)
        else begin
            errors++;
            $display("char_valid beyond the display credits given");
        end

    function automatic word_t nibble_merge(word_t old_w, word_t new_w, mask_t m);
        word_t bits;
        for (int n = 0; n < NIBBLES; n++) begin
            bits[4*n +: 4] = {4{m[n]}};
        end
        return (old_w & ~bits) | (new_w & bits);
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // one request, waits for a credit first
    task automatic host_send(logic wr, mask_t m, addr_t a, word_t d);
        while (credits_held == 0) tick();
        host_valid = 1'b1;
        host_wr    = wr;
        host_mask  = m;
        host_addr  = a;
        host_data  = d;
        if (wr) shadow[a] = nibble_merge(shadow[a], d, m);
        else begin
            rd_exp[rd_issued] = shadow[a];
            rd_issued++;
        end
        tick();
        host_valid = 1'b0;
    endtask

    task automatic host_drain();
        while (credits_held != HOST_CREDITS || rd_head != rd_issued) tick();
    endtask

    // sink gives each credit back `delay` cycles after its char
    task automatic run_fetch(addr_t base, int delay);
        int given = 0;
        int waited = 0;
        line_base  = base;
        line_start = 1'b1;
        tick();
        line_start = 1'b0;
        while (given < LINE_COLS) begin
            disp_credit = 1'b0;
            if (char_cnt > given) begin
                if (waited >= delay) begin
                    disp_credit = 1'b1;
                    given++;
                    waited = 0;
                end else waited++;
            end
            tick();
        end
        disp_credit = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        host_valid  = 1'b0;
        host_wr     = 1'b0;
        host_mask   = '0;
        host_addr   = '0;
        host_data   = '0;
        line_start  = 1'b0;
        line_base   = '0;
        disp_credit = 1'b0;
        for (int i = 0; i < 16; i++) begin
            test_addr[i] = {2'(i % BANKS), 14'($random(seed))};   // all four banks
        end
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        repeat (5) tick();
        started = 1'b1;

        for (int i = 0; i < 16; i++) host_send(1'b1, '1, test_addr[i], word_t'($random(seed)));
        for (int i = 0; i < 16; i++) host_send(1'b0, '0, test_addr[i], '0);
        host_drain();

        for (int i = 0; i < 16; i++) begin
            host_send(1'b1, mask_t'($random(seed)), test_addr[i], word_t'($random(seed)));
        end
        for (int i = 0; i < 16; i++) host_send(1'b0, '0, test_addr[i], '0);
        host_drain();

        // character rows for two lines
        for (int i = 0; i < LINE_COLS; i++) begin
            host_send(1'b1, '1, 16'h2100 + addr_t'(i), word_t'($random(seed)));
            host_send(1'b1, '1, 16'hc3f8 + addr_t'(i), word_t'($random(seed)));
        end
        host_drain();
        run_fetch(16'h2100, 0);

        // slow sink with host reads competing for the VRAM
        fork
            run_fetch(16'hc3f8, 6);
            for (int i = 0; i < 8; i++) host_send(1'b0, '0, test_addr[i], '0);
        join
        host_drain();
        repeat (4) tick();

        a_credit_total: assert (credit_pulses == accepted)
            else begin
                errors++;
                $display("credit pulses differ from accepted requests");
            end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: vram_subsys.f
verilog/vram_pkg.sv
verilog/vram_req_if.sv
verilog/host_port.sv
verilog/text_fetch.sv
verilog/vram_arbiter.sv
verilog/vram.sv
verilog/vram_subsys.sv
testbench/tb_vram_subsys.sv

// File: Bender.yml
package:
  name: vram_subsys

sources:
  - verilog/vram_pkg.sv
  - verilog/vram_req_if.sv
  - verilog/host_port.sv
  - verilog/text_fetch.sv
  - verilog/vram_arbiter.sv
  - verilog/vram.sv
  - verilog/vram_subsys.sv
  - target: test
    files:
      - testbench/tb_vram_subsys.sv
